//--- design/hostPkg.sv
/*
  Shared types and constants for the CPU host shell.
  DEBOUNCE_LEN is shortened for simulation; the board build uses 21.
  The RAM always sits in the lowest 1 KB block of the 64 KB space.
*/
package hostPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Slow tick period is 2**SLOW_BITS clocks
    localparam int SLOW_BITS = 8;
    // Consecutive tick samples before the reset counts as stable
    localparam int DEBOUNCE_LEN = 4;

    // Serial line, 8N1
    localparam int BIT_CLOCKS = 16;
    localparam int FRAME_BITS = 10;
    localparam int TIMER_BITS = $clog2(BIT_CLOCKS);
    localparam int COUNT_BITS = $clog2(FRAME_BITS);
    localparam logic [TIMER_BITS-1:0] BIT_LAST = TIMER_BITS'(BIT_CLOCKS - 1);
    localparam logic [COUNT_BITS-1:0] FRAME_LAST = COUNT_BITS'(FRAME_BITS - 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_BITS = 16;
    localparam int RAM_ADDR_BITS = 10;
    // Upper address bits that pick the RAM block
    localparam logic [ADDR_BITS-RAM_ADDR_BITS-1:0] RAM_BLOCK = '0;

    // I/O ports decode on address bits 7..0
    localparam logic [7:0] PORT_TX = 8'h00;
    localparam logic [7:0] PORT_STATUS = 8'h01;
    // Unmapped reads see the bus pull-ups
    localparam logic [7:0] IDLE_DATA = 8'hFF;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bus as the CPU drives it, strobes active low
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic nMreq;
        logic nIorq;
        logic nRd;
        logic nWr;
        logic nM1;    // reserved, opcode fetch marker
    } cpuBusT;

    // Decoder bus cycle tracking
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACCESS,
        BUS_RELEASE
    } busStateT;

endpackage

//--- design/clockReset.sv
/*
  Slow CPU tick and reset debouncer.
  The raw reset must be synchronous to clk; cpuReset follows it one clock late.
*/
module clockReset
    import hostPkg::*;
(
    input  logic clk,
    input  logic reset,
    output logic slowTick,
    output logic cpuReset
);

    // Free-running divider
    logic [SLOW_BITS-1:0] tickCount;
    // Reset samples, newest in bit 0
    logic [DEBOUNCE_LEN-1:0] samples;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tick generator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            tickCount <= '0;
            slowTick  <= 1'b0;
        end else begin
            tickCount <= tickCount + 1'b1;
            // One clock pulse as the counter wraps
            slowTick  <= (tickCount == '1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Debouncer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            // Button held: treat every sample as pressed
            samples  <= '1;
            cpuReset <= 1'b1;
        end else begin
            // Sample the button once per tick
            if (slowTick) begin
                samples <= {samples[DEBOUNCE_LEN-2:0], reset};
            end
            // Only change on a unanimous history, hold otherwise
            if (&samples) begin
                cpuReset <= 1'b1;
            end else if (samples == '0) begin
                cpuReset <= 1'b0;
            end
        end
    end

    // CPU reset only releases right behind a tick sample
    releaseAfterTick: assert property (
        @(posedge clk) disable iff (reset)
        $fell(cpuReset) |-> $past(slowTick, 2)
    );

endmodule

//--- design/busDecoder.sv
/*
  Bus cycle decoder: one action per strobe, however long it is held.
  No wait states; a port 0 write while the transmitter is busy is lost.
  Read data appears 2 clocks after the strobe is sampled.
*/
module busDecoder
    import hostPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  cpuBusT cpuBus,
    input  logic [7:0] dataIn,
    input  logic [7:0] ramData,
    input  logic txBusy,
    output logic [RAM_ADDR_BITS-1:0] ramAddr,
    output logic ramWrite,
    output logic [7:0] ramWriteData,
    output logic txStart,
    output logic [7:0] txData,
    output logic [7:0] dataOut
);

    cpuBusT busQ;
    logic [7:0] dataQ;
    busStateT state;
    // Read kind latched at cycle start
    logic readRamQ;
    logic readStatusQ;

    logic strobeLow;
    logic isRead;
    logic isWrite;
    logic memSel;
    logic ioSel;
    logic startCycle;
    logic [7:0] statusByte;

    // Bus register, strobes idle high after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            busQ <= '1;
        end else begin
            busQ <= cpuBus;
        end
    end

    always_ff @(posedge clk) begin
        dataQ <= dataIn;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cycle classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign strobeLow = !busQ.nRd || !busQ.nWr;
    // Both strobes low is malformed, starts a cycle with no action
    assign isRead  = !busQ.nRd && busQ.nWr;
    assign isWrite = busQ.nRd && !busQ.nWr;
    assign memSel  = busQ.nIorq && (busQ.addr[ADDR_BITS-1:RAM_ADDR_BITS] == RAM_BLOCK);
    assign ioSel   = !busQ.nIorq;
    // First clock of a bus cycle
    assign startCycle = (state == BUS_IDLE) && strobeLow;

    // Write strobes, valid for exactly one clock per cycle
    assign ramWrite = startCycle && memSel && isWrite;
    assign txStart  = startCycle && ioSel && isWrite && (busQ.addr[7:0] == PORT_TX) && !txBusy;

    assign ramAddr      = busQ.addr[RAM_ADDR_BITS-1:0];
    assign ramWriteData = dataQ;
    assign txData       = dataQ;
    assign statusByte   = {7'b0, txBusy};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cycle FSM and read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= BUS_IDLE;
            readRamQ    <= 1'b0;
            readStatusQ <= 1'b0;
            dataOut     <= IDLE_DATA;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (strobeLow) begin
                        state       <= BUS_ACCESS;
                        readRamQ    <= memSel && isRead;
                        readStatusQ <= ioSel && isRead && (busQ.addr[7:0] == PORT_STATUS);
                    end
                end
                BUS_ACCESS: begin
                    // RAM output is ready now, one clock after the address
                    state <= BUS_RELEASE;
                    if (readRamQ) begin
                        dataOut <= ramData;
                    end else if (readStatusQ) begin
                        dataOut <= statusByte;
                    end
                end
                BUS_RELEASE: begin
                    // Hold read data until both strobes are back high
                    if (!strobeLow) begin
                        state   <= BUS_IDLE;
                        dataOut <= IDLE_DATA;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // An action only on the first clock that a strobe is seen low
    oneAction: assert property (
        @(posedge clk) disable iff (reset)
        (ramWrite || txStart) |-> !$past(strobeLow)
    );

endmodule

//--- design/ramBlock.sv
/*
  1 KB single-port RAM, read registered, read-before-write on a collision.
  Contents are undefined at power-up.
*/
module ramBlock
    import hostPkg::*;
(
    input  logic clk,
    input  logic [RAM_ADDR_BITS-1:0] ramAddr,
    input  logic ramWrite,
    input  logic [7:0] ramWriteData,
    output logic [7:0] ramData
);

    // Maps onto block RAM
    logic [7:0] mem [2**RAM_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (ramWrite) begin
            mem[ramAddr] <= ramWriteData;
        end
        // Read every clock, the decoder picks when to use it
        ramData <= mem[ramAddr];
    end

endmodule

//--- design/uartTx.sv
/*
  8N1 transmitter, LSB first, BIT_CLOCKS clocks per bit.
  A start while busy is not queued, the caller must check txBusy.
*/
module uartTx
    import hostPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic txStart,
    input  logic [7:0] txData,
    output logic txLine,
    output logic txBusy
);

    // Frame shifts out of bit 0, ones fill from the top
    logic [FRAME_BITS-1:0] frame;
    logic [TIMER_BITS-1:0] bitTimer;
    logic [COUNT_BITS-1:0] bitCount;
    logic bitEnd;

    // Last clock of the current bit
    assign bitEnd = txBusy && (bitTimer == BIT_LAST);

    // Line idles high through the all-ones frame
    assign txLine = frame[0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            txBusy   <= 1'b0;
            bitTimer <= '0;
            bitCount <= '0;
        end else if (txStart && !txBusy) begin
            txBusy   <= 1'b1;
            bitTimer <= '0;
            bitCount <= '0;
        end else if (txBusy) begin
            bitTimer <= bitTimer + 1'b1;
            if (bitEnd) begin
                bitTimer <= '0;
                // Busy drops as the stop bit ends
                if (bitCount == FRAME_LAST) begin
                    txBusy <= 1'b0;
                end else begin
                    bitCount <= bitCount + 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shifter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            frame <= '1;
        end else if (txStart && !txBusy) begin
            // Stop, data, start
            frame <= {1'b1, txData, 1'b0};
        end else if (bitEnd) begin
            frame <= {1'b1, frame[FRAME_BITS-1:1]};
        end
    end

    // The decoder must have dropped any write during a frame
    noStartWhileBusy: assert property (
        @(posedge clk) disable iff (reset)
        txStart |-> !txBusy
    );

endmodule

//--- design/hostTop.sv
/*
  Host shell top for an external Z80-style CPU.
  Data bus is split into dataIn and dataOut, no tri-state.
  The CPU is expected to step on slowTick and to use cpuReset.
*/
module hostTop
    import hostPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  cpuBusT cpuBus,
    input  logic [7:0] dataIn,
    output logic [7:0] dataOut,
    output logic slowTick,
    output logic cpuReset,
    output logic txLine
);

    // RAM port
    logic [RAM_ADDR_BITS-1:0] ramAddr;
    logic ramWrite;
    logic [7:0] ramWriteData;
    logic [7:0] ramData;

    // Transmitter port
    logic txStart;
    logic [7:0] txData;
    logic txBusy;

    // Raw button only reaches this block
    clockReset u_clockReset (
        .clk      (clk),
        .reset    (reset),
        .slowTick (slowTick),
        .cpuReset (cpuReset)
    );

    busDecoder u_busDecoder (
        .clk          (clk),
        .reset        (cpuReset),
        .cpuBus       (cpuBus),
        .dataIn       (dataIn),
        .ramData      (ramData),
        .txBusy       (txBusy),
        .ramAddr      (ramAddr),
        .ramWrite     (ramWrite),
        .ramWriteData (ramWriteData),
        .txStart      (txStart),
        .txData       (txData),
        .dataOut      (dataOut)
    );

    ramBlock u_ramBlock (
        .clk          (clk),
        .ramAddr      (ramAddr),
        .ramWrite     (ramWrite),
        .ramWriteData (ramWriteData),
        .ramData      (ramData)
    );

    uartTx u_uartTx (
        .clk     (clk),
        .reset   (cpuReset),
        .txStart (txStart),
        .txData  (txData),
        .txLine  (txLine),
        .txBusy  (txBusy)
    );

endmodule

//--- bench/hostModel.svh
/*
  Bench model, included inside hostBench after its signals and counters.
  The RAM model only follows writes that land in the low 1 KB block.
*/
`ifndef HOST_MODEL_SVH
`define HOST_MODEL_SVH

// Expected RAM contents
logic [7:0] ramModel [2**RAM_ADDR_BITS];

function automatic void modelWrite(input logic [15:0] addr, input logic [7:0] data);
    // Writes outside the RAM block go nowhere
    if (addr[ADDR_BITS-1:RAM_ADDR_BITS] == RAM_BLOCK) begin
        ramModel[addr[RAM_ADDR_BITS-1:0]] = data;
    end
endfunction

// Byte a read of this address should return
function automatic logic [7:0] expectedRead(input logic [15:0] addr, input logic io,
                                            input logic busy);
    if (io) begin
        return (addr[7:0] == PORT_STATUS) ? {7'b0, busy} : IDLE_DATA;
    end
    if (addr[ADDR_BITS-1:RAM_ADDR_BITS] != RAM_BLOCK) begin
        return IDLE_DATA;
    end
    return ramModel[addr[RAM_ADDR_BITS-1:0]];
endfunction

// Line levels in send order, bit 0 goes out first
function automatic logic [FRAME_BITS-1:0] expectedFrame(input logic [7:0] data);
    logic [FRAME_BITS-1:0] bits;
    bits[0] = 1'b0;
    for (int i = 0; i < 8; i++) begin
        bits[i+1] = data[i];
    end
    bits[FRAME_BITS-1] = 1'b1;
    return bits;
endfunction

task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        valueErrors++;
        $display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
endtask

task automatic checkFrame(input string name, input logic [FRAME_BITS-1:0] got,
                          input logic [FRAME_BITS-1:0] exp);
    if (got !== exp) begin
        valueErrors++;
        $display("FAILED %s: got 0x%03h, expected 0x%03h", name, got, exp);
    end
endtask

task automatic checkLevel(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        valueErrors++;
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
endtask

// Samples one frame at bit centres, counted from the falling start edge
task automatic captureFrame(output logic [FRAME_BITS-1:0] bits);
    int waited;
    bits = '1;
    waited = 0;
    @(negedge clk);
    while (txLine === 1'b1 && waited < START_WAIT) begin
        @(negedge clk);
        waited++;
    end
    if (txLine !== 1'b0) begin
        otherErrors++;
        $display("ERROR: txLine never dropped to a start bit");
    end else begin
        // Half a clock past the edge now
        repeat (BIT_CLOCKS/2 - 1) @(negedge clk);
        for (int i = 0; i < FRAME_BITS; i++) begin
            bits[i] = txLine;
            if (i < FRAME_BITS - 1) begin
                repeat (BIT_CLOCKS) @(negedge clk);
            end
        end
    end
endtask

`endif

//--- bench/hostBench.sv
/*
  Testbench for hostTop, plays the CPU with strobes held HOLD_CLOCKS clocks.
  Outputs are sampled on the falling clock edge.
*/
module hostBench
    import hostPkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int SEED = 26011;
    localparam int HOLD_CLOCKS = 6;
    // Idle clocks so the decoder is back in idle
    localparam int GAP_CLOCKS = 3;
    localparam int START_WAIT = 16;
    localparam int RESET_WAIT = (DEBOUNCE_LEN + 2) * (2**SLOW_BITS);
    localparam int CYCLE_CLOCKS = HOLD_CLOCKS + GAP_CLOCKS + 2;
    localparam int FRAME_CLOCKS = FRAME_BITS * BIT_CLOCKS + BIT_CLOCKS + START_WAIT;
    // Reset phase, about 190 bus cycles, four frames and a two frame idle window
    localparam int RUN_CLOCKS = RESET_WAIT + 200 * CYCLE_CLOCKS + 7 * FRAME_CLOCKS;
    localparam int LIMIT_CLOCKS = RUN_CLOCKS + RUN_CLOCKS / 4;

    logic clk;
    logic reset;
    cpuBusT cpuBus;
    logic [7:0] dataIn;
    logic [7:0] dataOut;
    logic slowTick;
    logic cpuReset;
    logic txLine;
    int valueErrors;
    int otherErrors;
    // RAM addresses written in the round trip
    logic [15:0] addrList [$];

    `include "hostModel.svh"

    hostTop u_hostTop (
        .clk      (clk),
        .reset    (reset),
        .cpuBus   (cpuBus),
        .dataIn   (dataIn),
        .dataOut  (dataOut),
        .slowTick (slowTick),
        .cpuReset (cpuReset),
        .txLine   (txLine)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU bus driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic cpuBusT busValue(input logic [15:0] addr, input logic io,
                                        input logic rd, input logic wr);
        cpuBusT v;
        v.addr  = addr;
        // Request lines only while a strobe is out
        v.nMreq = !(rd || wr) || io;
        v.nIorq = !(rd || wr) || !io;
        v.nRd   = !rd;
        v.nWr   = !wr;
        v.nM1   = 1'b1;
        return v;
    endfunction

    // One full bus cycle, read data taken just before the strobe rises
    task automatic busAccess(input logic [15:0] addr, input logic io, input logic write,
                             input logic [7:0] data, output logic [7:0] readData);
        @(posedge clk);
        cpuBus <= busValue(addr, io, !write, write);
        dataIn <= data;
        repeat (HOLD_CLOCKS - 1) @(posedge clk);
        @(negedge clk);
        readData = dataOut;
        @(posedge clk);
        cpuBus <= busValue(addr, io, 1'b0, 1'b0);
        repeat (GAP_CLOCKS) @(posedge clk);
        @(negedge clk);
        checkByte("dataOut between cycles", dataOut, IDLE_DATA);
    endtask

    task automatic writeMem(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] got;
        busAccess(addr, 1'b0, 1'b1, data, got);
        modelWrite(addr, data);
    endtask

    task automatic readExpect(input logic [15:0] addr, input logic io, input logic busy,
                              input string name);
        logic [7:0] got;
        busAccess(addr, io, 1'b0, 8'h00, got);
        checkByte(name, got, expectedRead(addr, io, busy));
    endtask

    task automatic sendByte(input logic [7:0] data);
        logic [7:0] got;
        busAccess({8'h00, PORT_TX}, 1'b1, 1'b1, data, got);
    endtask

    task automatic frameTest(input logic [7:0] data);
        logic [FRAME_BITS-1:0] bits;
        fork
            sendByte(data);
            captureFrame(bits);
        join
        checkFrame("txLine frame", bits, expectedFrame(data));
        // Let the stop bit finish
        repeat (BIT_CLOCKS) @(posedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [15:0] addr;
        logic [7:0] data;
        logic [ADDR_BITS-RAM_ADDR_BITS-1:0] block;
        logic [FRAME_BITS-1:0] bits;
        logic lineLow;
        int ticks;
        int waited;
        void'($urandom(SEED));
        valueErrors = 0;
        otherErrors = 0;
        reset = 1'b1;
        cpuBus = busValue(16'h0000, 1'b0, 1'b0, 1'b0);
        dataIn = 8'h00;

        // Button held for 4 clocks
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkLevel("cpuReset while reset held", cpuReset, 1'b1);
        @(posedge clk);
        reset <= 1'b0;
        ticks = 0;
        waited = 0;
        @(negedge clk);
        while (cpuReset === 1'b1 && waited < RESET_WAIT) begin
            // One clock pulse every 2**SLOW_BITS clocks after the button lets go
            checkLevel("slowTick", slowTick,
                       waited > 0 && waited % (2**SLOW_BITS) == 0);
            ticks += slowTick;
            waited++;
            @(negedge clk);
        end
        if (cpuReset !== 1'b0) begin
            otherErrors++;
            $display("ERROR: cpuReset never released after the button let go");
        end
        checkByte("slowTick count at cpuReset release", 8'(ticks), 8'(DEBOUNCE_LEN));

        // RAM round trip
        for (int i = 0; i < 64; i++) begin
            addr = {RAM_BLOCK, RAM_ADDR_BITS'($urandom)};
            data = 8'($urandom);
            writeMem(addr, data);
            addrList.push_back(addr);
        end
        foreach (addrList[i]) begin
            readExpect(addrList[i], 1'b0, 1'b0, "dataOut RAM read");
        end

        // Aliased writes above the RAM block must miss
        for (int i = 0; i < 16; i++) begin
            block = $urandom_range(2**(ADDR_BITS-RAM_ADDR_BITS) - 1, 1);
            addr = {block, addrList[i][RAM_ADDR_BITS-1:0]};
            writeMem(addr, 8'($urandom));
            readExpect(addrList[i], 1'b0, 1'b0, "dataOut RAM after unmapped write");
            readExpect(addr, 1'b0, 1'b0, "dataOut unmapped memory read");
        end
        readExpect({8'h00, 8'($urandom_range(255, 2))}, 1'b1, 1'b0, "dataOut unmapped port");

        repeat (3) frameTest(8'($urandom));

        // Status poll and a dropped write inside one frame
        data = 8'($urandom);
        fork
            captureFrame(bits);
            begin
                sendByte(data);
                readExpect({8'h00, PORT_STATUS}, 1'b1, 1'b1, "dataOut status busy");
                sendByte(~data);
            end
        join
        checkFrame("txLine frame with dropped write", bits, expectedFrame(data));
        repeat (BIT_CLOCKS) @(posedge clk);
        readExpect({8'h00, PORT_STATUS}, 1'b1, 1'b0, "dataOut status idle");
        lineLow = 1'b0;
        repeat (2 * FRAME_BITS * BIT_CLOCKS) begin
            @(negedge clk);
            lineLow |= !txLine;
        end
        checkLevel("txLine low after dropped write", lineLow, 1'b0);

        $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(LIMIT_CLOCKS * CLK_PERIOD);
        $display("ERROR: run did not finish within %0d clocks", LIMIT_CLOCKS);
        $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors + 1);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- list.f
+incdir+bench
design/hostPkg.sv
design/clockReset.sv
design/busDecoder.sv
design/ramBlock.sv
design/uartTx.sv
design/hostTop.sv
bench/hostBench.sv

//--- Bender.yml
package:
  name: hostShell

sources:
  - files:
      - design/hostPkg.sv
      - design/clockReset.sv
      - design/busDecoder.sv
      - design/ramBlock.sv
      - design/uartTx.sv
      - design/hostTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/hostBench.sv
